// File: compile.f
hw/lsu_pkg.sv
hw/lsu_issue_fifo.sv
hw/lsu_agu.sv
hw/lsu_store_queue.sv
hw/lsu_mem_arb.sv
hw/lsu_writeback.sv
hw/lsu_top.sv
sim/lsu_properties.sv
sim/lsu_monitor.sv
sim/lsu_tb.sv

// File: run.sh
#!/bin/sh
# build and run with Verilator, then scan the log
verilator --binary --timing --assert -Wno-fatal --top-module lsu_tb -f compile.f -o lsu_sim \
    && { ./obj_dir/lsu_sim > sim.log 2>&1 || true; } \
    && cat sim.log \
    && ! grep -q "Test failed" sim.log \
    && grep -q "Test passed" sim.log \
    || { echo "simulation failed, see sim.log"; exit 1; }

// File: sim/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb;
    import lsu_pkg::*;

    localparam int    NUM_OPS        = 2000;
    localparam int    CLK_PERIOD     = 20;
    localparam int    RESET_CYCLES   = 10;
    localparam int    TIMEOUT_CYCLES = NUM_OPS * 40;
    localparam int    SEED           = 59888;
    // all traffic lands in one 256-byte window
    localparam addr_t WIN_BASE       = 32'h0000_2000;

    logic       clk;
    logic       rst_n;
    logic       issue_valid;
    logic       issue_ready;
    lsu_op_t    issue_op;
    logic       st_commit_en;
    logic       stq_commit_en;
    inst_idx_t  stq_commit_id;
    logic       mem_req_valid;
    logic       mem_req_ready;
    mem_req_t   mem_req;
    logic       mem_ack_valid;
    line_data_t mem_ack_data;
    load_tag_t  mem_ack_tag;
    logic       reg_wr_en;
    phy_reg_t   reg_index;
    reg_data_t  reg_val;
    logic       ld_commit_en;
    inst_idx_t  ld_commit_id;

    int error_count;
    int check_count;
    int loads_done;
    int stores_done;
    int issued_loads     = 0;
    int issued_stores    = 0;
    int committed_stores = 0;
    int cycle            = 0;

    // memory model state
    logic [7:0] mem [256];
    line_data_t ack_data_q [$];
    load_tag_t  ack_tag_q [$];
    int         ack_due_q [$];

    lsu_top dut0 (.*);

    lsu_monitor u_monitor (.*);

    bind lsu_top lsu_properties u_properties (
        .clk           (clk          ),
        .rst_n         (rst_n        ),
        .issue_ready   (issue_ready  ),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req       (mem_req      ),
        .mem_ack_valid (mem_ack_valid),
        .reg_wr_en     (reg_wr_en    ),
        .ld_commit_en  (ld_commit_en ),
        .stq_commit_en (stq_commit_en)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //################################################
    // stimulus
    //################################################
    // aligned address in the window, reached through a random signed offset
    task automatic make_op(output lsu_op_t op);
        int    nbytes;
        addr_t addr;
        op.is_store  = 1'($urandom);
        op.size      = mem_size_e'(2'($urandom % 3));
        op.is_signed = 1'($urandom);
        op.inst_id   = inst_idx_t'($urandom);
        op.rd        = phy_reg_t'($urandom);
        op.st_data   = $urandom;
        nbytes       = 1 << op.size;
        addr         = WIN_BASE + 32'(($urandom % 256) & ~(nbytes - 1));
        op.offset    = offset_t'($urandom);
        op.base      = addr - {{(ADDR_WIDTH-OFFSET_WIDTH){op.offset[OFFSET_WIDTH-1]}}, op.offset};
    endtask

    initial begin
        lsu_op_t op;
        logic    accepted;
        int      seed_val;
        seed_val      = $urandom(SEED);
        rst_n         = 1'b0;
        issue_valid   = 1'b0;
        issue_op      = '0;
        st_commit_en  = 1'b0;
        mem_req_ready = 1'b0;
        mem_ack_valid = 1'b0;
        mem_ack_data  = '0;
        mem_ack_tag   = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
        for (int n = 0; n < NUM_OPS; n++) begin
            make_op(op);
            accepted = 1'b0;
            while (!accepted) begin
                issue_valid = ($urandom % 4 != 0);
                issue_op    = op;
                // ready is registered, so the negedge value holds at the next edge
                @(negedge clk);
                accepted = issue_valid && issue_ready;
                if (accepted && op.is_store) begin
                    issued_stores++;
                end else if (accepted) begin
                    issued_loads++;
                end
                @(posedge clk);
                #1;
            end
        end
        issue_valid = 1'b0;
        wait (loads_done == issued_loads && stores_done == issued_stores);
        repeat (5) @(posedge clk);
        $display("checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // commit only stores that were already accepted
    initial begin
        @(posedge rst_n);
        forever begin
            @(posedge clk);
            #1;
            st_commit_en = (committed_stores < issued_stores) && ($urandom % 3 == 0);
            if (st_commit_en) begin
                committed_stores++;
            end
        end
    end

    //################################################
    // memory model
    //################################################
    task automatic serve_request();
        logic [2:0] line_idx;
        line_data_t line;
        line_idx = mem_req.addr[7:5];
        if (mem_req.opcode == MEM_WRITE) begin
            for (int i = 0; i < LINE_BYTES; i++) begin
                if (mem_req.strb[i]) begin
                    mem[{line_idx, 5'(i)}] = mem_req.data[i*8 +: 8];
                end
            end
        end else begin
            for (int i = 0; i < LINE_BYTES; i++) begin
                line[i*8 +: 8] = mem[{line_idx, 5'(i)}];
            end
            ack_data_q.push_back(line);
            ack_tag_q.push_back(mem_req.sideband);
            ack_due_q.push_back(cycle + 1 + int'($urandom % 4));
        end
    endtask

    // acks leave strictly in request order
    task automatic drive_ack();
        mem_ack_valid = 1'b0;
        if (ack_due_q.size() > 0 && ack_due_q[0] <= cycle) begin
            mem_ack_valid = 1'b1;
            mem_ack_data  = ack_data_q.pop_front();
            mem_ack_tag   = ack_tag_q.pop_front();
            void'(ack_due_q.pop_front());
        end
    endtask

    initial begin
        for (int k = 0; k < 256; k++) begin
            mem[k] = 8'((k * 37) ^ (k >> 3) ^ 8'hc5);
        end
        forever begin
            @(negedge clk);
            if (rst_n && mem_req_valid && mem_req_ready) begin
                serve_request();
            end
            @(posedge clk);
            #1;
            cycle++;
            mem_req_ready = ($urandom % 4 != 0);
            drive_ack();
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("run timed out after %0d cycles: %0d of %0d loads, %0d of %0d stores done",
                 TIMEOUT_CYCLES, loads_done, issued_loads, stores_done, issued_stores);
        $display("checks: %0d  errors: %0d", check_count, error_count);
        $display("Test failed");
        $finish;
    end

endmodule

// File: sim/lsu_monitor.sv
`timescale 1ns/1ps

module lsu_monitor (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               issue_valid,
    input  logic               issue_ready,
    input  lsu_pkg::lsu_op_t   issue_op,
    input  logic               st_commit_en,
    input  logic               stq_commit_en,
    input  lsu_pkg::inst_idx_t stq_commit_id,
    input  logic               mem_req_valid,
    input  logic               mem_req_ready,
    input  lsu_pkg::mem_req_t  mem_req,
    input  logic               mem_ack_valid,
    input  logic               reg_wr_en,
    input  lsu_pkg::phy_reg_t  reg_index,
    input  lsu_pkg::reg_data_t reg_val,
    input  logic               ld_commit_en,
    input  lsu_pkg::inst_idx_t ld_commit_id,
    output int                 error_count,
    output int                 check_count,
    output int                 loads_done,
    output int                 stores_done
);
    import lsu_pkg::*;

    typedef struct packed {
        phy_reg_t  rd;
        inst_idx_t inst_id;
        reg_data_t val;
    } wb_expect_t;

    lsu_op_t    store_q [$];
    lsu_op_t    load_q [$];
    wb_expect_t wb_q [$];
    logic [7:0] mirror [256];
    int         commit_pulses;
    int         write_count;
    // responses owed in the cycle after an event
    logic       write_seen;
    inst_idx_t  write_id;
    logic       ack_seen;

    //################################################
    // reference model
    //################################################
    function automatic addr_t op_addr(input lsu_op_t op);
        return op.base + {{(ADDR_WIDTH-OFFSET_WIDTH){op.offset[OFFSET_WIDTH-1]}}, op.offset};
    endfunction

    function automatic int size_bytes(input mem_size_e size);
        case (size)
            MEM_SIZE_BYTE: return 1;
            MEM_SIZE_HALF: return 2;
            default:       return 4;
        endcase
    endfunction

    function automatic reg_data_t load_value(input lsu_op_t op);
        reg_data_t raw;
        addr_t     addr;
        int        n;
        raw  = '0;
        addr = op_addr(op);
        n    = size_bytes(op.size);
        for (int i = 0; i < n; i++) begin
            raw[i*8 +: 8] = mirror[addr[7:0] + 8'(i)];
        end
        // sign fill above the loaded bytes
        if (op.is_signed && n < REG_BYTES && raw[n*8-1]) begin
            raw = raw | ({REG_WIDTH{1'b1}} << (n * 8));
        end
        return raw;
    endfunction

    //################################################
    // reporting
    //################################################
    task automatic flag_error(input string what);
        error_count++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    task automatic compare_word(input string what, input reg_data_t got, input reg_data_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic compare_line(input string what, input line_data_t got, input line_data_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    //################################################
    // per-event checks
    //################################################
    task automatic check_store();
        lsu_op_t    op;
        addr_t      addr;
        int         n;
        reg_data_t  masked;
        line_data_t exp_data;
        line_strb_t exp_strb;
        if (store_q.size() == 0) begin
            flag_error("write request seen with no issued store outstanding");
            return;
        end
        op = store_q.pop_front();
        write_count++;
        if (write_count > commit_pulses) begin
            flag_error("write request sent before its store was committed");
        end
        addr   = op_addr(op);
        n      = size_bytes(op.size);
        masked = '0;
        for (int i = 0; i < n; i++) begin
            masked[i*8 +: 8]              = op.st_data[i*8 +: 8];
            mirror[addr[7:0] + 8'(i)] = op.st_data[i*8 +: 8];
        end
        exp_data = line_data_t'(masked) << (addr[4:0] * 8);
        exp_strb = line_strb_t'((1 << n) - 1) << addr[4:0];
        compare_word("store address", mem_req.addr, addr);
        compare_line("store data", mem_req.data, exp_data);
        compare_word("store strobes", mem_req.strb, exp_strb);
        write_seen = 1'b1;
        write_id   = op.inst_id;
    endtask

    task automatic check_load();
        lsu_op_t    op;
        wb_expect_t exp;
        if (load_q.size() == 0) begin
            flag_error("read request seen with no issued load outstanding");
            return;
        end
        op = load_q.pop_front();
        compare_word("load address", mem_req.addr, op_addr(op));
        exp.rd      = op.rd;
        exp.inst_id = op.inst_id;
        // value as memory stands at this read handshake
        exp.val     = load_value(op);
        wb_q.push_back(exp);
    endtask

    task automatic check_writeback();
        wb_expect_t exp;
        if (wb_q.size() == 0) begin
            flag_error("register writeback with no load outstanding");
            return;
        end
        exp = wb_q.pop_front();
        loads_done++;
        compare_word("writeback register", 32'(reg_index), 32'(exp.rd));
        compare_word("writeback value", reg_val, exp.val);
        compare_word("load commit tag", 32'(ld_commit_id), 32'(exp.inst_id));
    endtask

    // sampled at negedge where inputs and registered outputs are settled
    always @(negedge clk) begin
        if (!rst_n) begin
            error_count   = 0;
            check_count   = 0;
            loads_done    = 0;
            stores_done   = 0;
            commit_pulses = 0;
            write_count   = 0;
            write_seen    = 1'b0;
            ack_seen      = 1'b0;
            for (int i = 0; i < 256; i++) begin
                mirror[i] = 8'((i * 37) ^ (i >> 3) ^ 8'hc5);
            end
        end else begin
            compare_word("writeback enable", 32'(reg_wr_en), 32'(ack_seen));
            compare_word("load commit enable", 32'(ld_commit_en), 32'(ack_seen));
            if (reg_wr_en) begin
                check_writeback();
            end
            compare_word("store commit enable", 32'(stq_commit_en), 32'(write_seen));
            if (write_seen) begin
                stores_done++;
                compare_word("store commit tag", 32'(stq_commit_id), 32'(write_id));
            end
            write_seen = 1'b0;
            if (issue_valid && issue_ready) begin
                if (issue_op.is_store) begin
                    store_q.push_back(issue_op);
                end else begin
                    load_q.push_back(issue_op);
                end
            end
            if (mem_req_valid && mem_req_ready) begin
                if (mem_req.opcode == MEM_WRITE) begin
                    check_store();
                end else begin
                    check_load();
                end
            end
            // a commit takes effect at the coming edge, after any write there
            if (st_commit_en) begin
                commit_pulses++;
            end
            ack_seen = mem_ack_valid;
        end
    end

endmodule

// File: sim/lsu_properties.sv
`timescale 1ns/1ps

module lsu_properties (
    input logic              clk,
    input logic              rst_n,
    input logic              issue_ready,
    input logic              mem_req_valid,
    input logic              mem_req_ready,
    input lsu_pkg::mem_req_t mem_req,
    input logic              mem_ack_valid,
    input logic              reg_wr_en,
    input logic              ld_commit_en,
    input logic              stq_commit_en
);
    import lsu_pkg::*;

    logic write_hs;

    assign write_hs = mem_req_valid && mem_req_ready && (mem_req.opcode == MEM_WRITE);

    // stalled request keeps its payload
    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
        else $error("memory request changed while stalled");

    reset_quiet: assert property (@(posedge clk)
        !rst_n && $past(!rst_n) |->
            !issue_ready && !mem_req_valid && !reg_wr_en && !ld_commit_en && !stq_commit_en)
        else $error("control output high during reset");

    //################################################
    // one-cycle reports
    //################################################
    commit_after_write: assert property (@(posedge clk) disable iff (!rst_n)
        write_hs |=> stq_commit_en)
        else $error("no store commit report after write request");

    commit_needs_write: assert property (@(posedge clk) disable iff (!rst_n)
        stq_commit_en |-> $past(write_hs))
        else $error("store commit report without write request");

    wb_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
        mem_ack_valid |=> reg_wr_en && ld_commit_en)
        else $error("no writeback after memory acknowledge");

endmodule

// File: hw/lsu_top.sv
`timescale 1ns/1ps

module lsu_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                issue_valid,
    output logic                issue_ready,
    input  lsu_pkg::lsu_op_t    issue_op,
    input  logic                st_commit_en,
    output logic                stq_commit_en,
    output lsu_pkg::inst_idx_t  stq_commit_id,
    output logic                mem_req_valid,
    input  logic                mem_req_ready,
    output lsu_pkg::mem_req_t   mem_req,
    input  logic                mem_ack_valid,
    input  lsu_pkg::line_data_t mem_ack_data,
    input  lsu_pkg::load_tag_t  mem_ack_tag,
    output logic                reg_wr_en,
    output lsu_pkg::phy_reg_t   reg_index,
    output lsu_pkg::reg_data_t  reg_val,
    output logic                ld_commit_en,
    output lsu_pkg::inst_idx_t  ld_commit_id
);
    import lsu_pkg::*;

    logic    fifo_valid;
    logic    fifo_ready;
    lsu_op_t fifo_op;
    logic    agu_ld_valid;
    logic    agu_ld_ready;
    logic    agu_st_valid;
    logic    agu_st_ready;
    agu_op_t agu_op;
    logic    stq_req_valid;
    logic    stq_req_ready;
    agu_op_t stq_req_op;

    //################################################
    // issue and address generation
    //################################################
    lsu_issue_fifo u_issue_fifo (
        .clk       (clk          ),
        .rst_n     (rst_n        ),
        .in_valid  (issue_valid  ),
        .in_ready  (issue_ready  ),
        .in_op     (issue_op     ),
        .out_valid (fifo_valid   ),
        .out_ready (fifo_ready   ),
        .out_op    (fifo_op      )
    );

    lsu_agu u_agu (
        .clk       (clk          ),
        .rst_n     (rst_n        ),
        .in_valid  (fifo_valid   ),
        .in_ready  (fifo_ready   ),
        .in_op     (fifo_op      ),
        .ld_valid  (agu_ld_valid ),
        .ld_ready  (agu_ld_ready ),
        .st_valid  (agu_st_valid ),
        .st_ready  (agu_st_ready ),
        .out_op    (agu_op       )
    );

    //################################################
    // stores, arbitration, writeback
    //################################################
    lsu_store_queue u_store_queue (
        .clk           (clk           ),
        .rst_n         (rst_n         ),
        .st_valid      (agu_st_valid  ),
        .st_ready      (agu_st_ready  ),
        .st_op         (agu_op        ),
        .st_commit_en  (st_commit_en  ),
        .req_valid     (stq_req_valid ),
        .req_ready     (stq_req_ready ),
        .req_op        (stq_req_op    ),
        .stq_commit_en (stq_commit_en ),
        .stq_commit_id (stq_commit_id )
    );

    lsu_mem_arb u_mem_arb (
        .clk           (clk           ),
        .rst_n         (rst_n         ),
        .ld_valid      (agu_ld_valid  ),
        .ld_ready      (agu_ld_ready  ),
        .ld_op         (agu_op        ),
        .st_valid      (stq_req_valid ),
        .st_ready      (stq_req_ready ),
        .st_op         (stq_req_op    ),
        .mem_req_valid (mem_req_valid ),
        .mem_req_ready (mem_req_ready ),
        .mem_req       (mem_req       )
    );

    lsu_writeback u_writeback (
        .clk           (clk           ),
        .rst_n         (rst_n         ),
        .mem_ack_valid (mem_ack_valid ),
        .mem_ack_data  (mem_ack_data  ),
        .mem_ack_tag   (mem_ack_tag   ),
        .reg_wr_en     (reg_wr_en     ),
        .reg_index     (reg_index     ),
        .reg_val       (reg_val       ),
        .ld_commit_en  (ld_commit_en  ),
        .ld_commit_id  (ld_commit_id  )
    );

endmodule

// File: hw/lsu_writeback.sv
`timescale 1ns/1ps

module lsu_writeback (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                mem_ack_valid,
    input  lsu_pkg::line_data_t mem_ack_data,
    input  lsu_pkg::load_tag_t  mem_ack_tag,
    output logic                reg_wr_en,
    output lsu_pkg::phy_reg_t   reg_index,
    output lsu_pkg::reg_data_t  reg_val,
    output logic                ld_commit_en,
    output lsu_pkg::inst_idx_t  ld_commit_id
);
    import lsu_pkg::*;

    line_data_t shifted;
    reg_data_t  word;
    reg_data_t  ext_val;
    logic       sign_bit;

    // pick the loaded bytes out of the beat
    assign shifted = mem_ack_data >> {mem_ack_tag.lane, 3'b000};
    assign word    = shifted[REG_WIDTH-1:0];

    always_comb begin
        case (mem_ack_tag.size)
            MEM_SIZE_BYTE: begin
                sign_bit = mem_ack_tag.is_signed && word[7];
                ext_val  = {{(REG_WIDTH-8){sign_bit}}, word[7:0]};
            end
            MEM_SIZE_HALF: begin
                sign_bit = mem_ack_tag.is_signed && word[15];
                ext_val  = {{(REG_WIDTH-16){sign_bit}}, word[15:0]};
            end
            default: begin
                sign_bit = 1'b0;
                ext_val  = word;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_wr_en    <= 1'b0;
            ld_commit_en <= 1'b0;
        end else begin
            reg_wr_en    <= mem_ack_valid;
            ld_commit_en <= mem_ack_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_ack_valid) begin
            reg_index    <= mem_ack_tag.rd;
            reg_val      <= ext_val;
            ld_commit_id <= mem_ack_tag.inst_id;
        end
    end

endmodule

// File: hw/lsu_mem_arb.sv
`timescale 1ns/1ps

module lsu_mem_arb (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ld_valid,
    output logic              ld_ready,
    input  lsu_pkg::agu_op_t  ld_op,
    input  logic              st_valid,
    output logic              st_ready,
    input  lsu_pkg::agu_op_t  st_op,
    output logic              mem_req_valid,
    input  logic              mem_req_ready,
    output lsu_pkg::mem_req_t mem_req
);
    import lsu_pkg::*;

    logic                 grant_st;
    logic                 st_hold;
    agu_op_t              sel_op;
    lane_t                lane;
    logic [REG_BYTES-1:0] byte_en;
    reg_data_t            data_mask;

    //################################################
    // priority, load first
    //################################################
    // a stalled store keeps the port so the request stays stable
    assign grant_st      = st_hold || !ld_valid;
    assign sel_op        = grant_st ? st_op : ld_op;
    assign mem_req_valid = ld_valid || st_valid;
    assign ld_ready      = !grant_st && mem_req_ready;
    assign st_ready      = grant_st && mem_req_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st_hold <= 1'b0;
        end else begin
            st_hold <= grant_st && st_valid && !mem_req_ready;
        end
    end

    //################################################
    // byte lane alignment
    //################################################
    assign lane = sel_op.addr[LANE_WIDTH-1:0];

    always_comb begin
        case (sel_op.size)
            MEM_SIZE_BYTE: byte_en = 'b1;
            MEM_SIZE_HALF: byte_en = 'b11;
            default:       byte_en = '1;
        endcase
        for (int i = 0; i < REG_BYTES; i++) begin
            data_mask[i*8 +: 8] = {8{byte_en[i]}};
        end
    end

    always_comb begin
        mem_req                    = '0;
        mem_req.addr               = sel_op.addr;
        mem_req.opcode             = sel_op.is_store ? MEM_WRITE : MEM_READ;
        mem_req.sideband.inst_id   = sel_op.inst_id;
        mem_req.sideband.rd        = sel_op.rd;
        mem_req.sideband.size      = sel_op.size;
        mem_req.sideband.is_signed = sel_op.is_signed;
        mem_req.sideband.lane      = lane;
        if (sel_op.is_store) begin
            mem_req.data = line_data_t'(sel_op.st_data & data_mask) << {lane, 3'b000};
            mem_req.strb = line_strb_t'(byte_en) << lane;
        end
    end

endmodule

// File: hw/lsu_store_queue.sv
`timescale 1ns/1ps

module lsu_store_queue (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               st_valid,
    output logic               st_ready,
    input  lsu_pkg::agu_op_t   st_op,
    input  logic               st_commit_en,
    output logic               req_valid,
    input  logic               req_ready,
    output lsu_pkg::agu_op_t   req_op,
    output logic               stq_commit_en,
    output lsu_pkg::inst_idx_t stq_commit_id
);
    import lsu_pkg::*;

    agu_op_t  entries [STQ_DEPTH];
    stq_ptr_t wr_ptr;
    stq_ptr_t rd_ptr;
    stq_cnt_t count;
    // committed stores not yet sent, oldest first
    stq_cnt_t cmt_cnt;
    logic     push;
    logic     pop;

    function automatic stq_ptr_t ptr_inc(input stq_ptr_t ptr);
        return (ptr == stq_ptr_t'(STQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign st_ready  = (count != stq_cnt_t'(STQ_DEPTH));
    assign push      = st_valid && st_ready;
    // head goes out only once it is in the queue and committed
    assign req_valid = (count != '0) && (cmt_cnt != '0);
    assign pop       = req_valid && req_ready;
    assign req_op    = entries[rd_ptr];

    //################################################
    // pointers and counters
    //################################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            cmt_cnt <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            case ({st_commit_en, pop})
                2'b10:   cmt_cnt <= cmt_cnt + 1'b1;
                2'b01:   cmt_cnt <= cmt_cnt - 1'b1;
                default: cmt_cnt <= cmt_cnt;
            endcase
        end
    end

    // report one cycle after the write handshake
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stq_commit_en <= 1'b0;
        end else begin
            stq_commit_en <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= st_op;
        end
        if (pop) begin
            stq_commit_id <= req_op.inst_id;
        end
    end

endmodule

// File: hw/lsu_agu.sv
`timescale 1ns/1ps

module lsu_agu (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    output logic             in_ready,
    input  lsu_pkg::lsu_op_t in_op,
    output logic             ld_valid,
    input  logic             ld_ready,
    output logic             st_valid,
    input  logic             st_ready,
    output lsu_pkg::agu_op_t out_op
);
    import lsu_pkg::*;

    logic    op_valid;
    agu_op_t op_q;
    agu_op_t op_nxt;
    addr_t   offset_ext;
    logic    out_fire;

    //################################################
    // address generation
    //################################################
    assign offset_ext = {{(ADDR_WIDTH-OFFSET_WIDTH){in_op.offset[OFFSET_WIDTH-1]}}, in_op.offset};

    always_comb begin
        op_nxt.is_store  = in_op.is_store;
        op_nxt.size      = in_op.size;
        op_nxt.is_signed = in_op.is_signed;
        op_nxt.inst_id   = in_op.inst_id;
        op_nxt.rd        = in_op.rd;
        op_nxt.addr      = in_op.base + offset_ext;
        op_nxt.st_data   = in_op.st_data;
    end

    // steer by op type
    assign ld_valid = op_valid && !op_q.is_store;
    assign st_valid = op_valid && op_q.is_store;
    assign out_fire = (ld_valid && ld_ready) || (st_valid && st_ready);
    assign in_ready = !op_valid || out_fire;
    assign out_op   = op_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_valid <= 1'b0;
        end else if (in_ready) begin
            op_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            op_q <= op_nxt;
        end
    end

endmodule

// File: hw/lsu_issue_fifo.sv
`timescale 1ns/1ps

module lsu_issue_fifo (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    output logic             in_ready,
    input  lsu_pkg::lsu_op_t in_op,
    output logic             out_valid,
    input  logic             out_ready,
    output lsu_pkg::lsu_op_t out_op
);
    import lsu_pkg::*;

    lsu_op_t    entries [ISSUE_DEPTH];
    issue_ptr_t wr_ptr;
    issue_ptr_t rd_ptr;
    issue_cnt_t count;
    issue_cnt_t count_nxt;
    logic       push;
    logic       pop;

    function automatic issue_ptr_t ptr_inc(input issue_ptr_t ptr);
        return (ptr == issue_ptr_t'(ISSUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;
    assign out_valid = (count != '0);
    assign out_op    = entries[rd_ptr];

    always_comb begin
        case ({push, pop})
            2'b10:   count_nxt = count + 1'b1;
            2'b01:   count_nxt = count - 1'b1;
            default: count_nxt = count;
        endcase
    end

    // ready is registered so it sits low through reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            in_ready <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count    <= count_nxt;
            in_ready <= (count_nxt != issue_cnt_t'(ISSUE_DEPTH));
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= in_op;
        end
    end

endmodule

// File: hw/lsu_pkg.sv
package lsu_pkg;

    //################################################
    // widths and depths
    //################################################
    localparam int ADDR_WIDTH       = 32;
    localparam int LINE_BYTES       = 32;
    localparam int LINE_WIDTH       = 256;
    localparam int REG_WIDTH        = 32;
    localparam int REG_BYTES        = REG_WIDTH / 8;
    localparam int PHY_REG_ID_WIDTH = 6;
    localparam int INST_IDX_WIDTH   = 5;
    localparam int OFFSET_WIDTH     = 12;
    localparam int LANE_WIDTH       = $clog2(LINE_BYTES);
    localparam int ISSUE_DEPTH      = 4;
    localparam int STQ_DEPTH        = 4;
    // commits can run ahead of stores still sitting in the fifo or agu
    localparam int STQ_CMT_MAX      = ISSUE_DEPTH + STQ_DEPTH + 1;

    //################################################
    // plain vectors
    //################################################
    typedef logic [ADDR_WIDTH-1:0]               addr_t;
    typedef logic [REG_WIDTH-1:0]                reg_data_t;
    typedef logic [LINE_WIDTH-1:0]               line_data_t;
    typedef logic [LINE_BYTES-1:0]               line_strb_t;
    typedef logic [PHY_REG_ID_WIDTH-1:0]         phy_reg_t;
    typedef logic [INST_IDX_WIDTH-1:0]           inst_idx_t;
    typedef logic [OFFSET_WIDTH-1:0]             offset_t;
    typedef logic [LANE_WIDTH-1:0]               lane_t;
    typedef logic [$clog2(ISSUE_DEPTH)-1:0]      issue_ptr_t;
    typedef logic [$clog2(ISSUE_DEPTH+1)-1:0]    issue_cnt_t;
    typedef logic [$clog2(STQ_DEPTH)-1:0]        stq_ptr_t;
    typedef logic [$clog2(STQ_CMT_MAX+1)-1:0]    stq_cnt_t;

    typedef enum logic [1:0] {
        MEM_SIZE_BYTE = 2'd0,
        MEM_SIZE_HALF = 2'd1,
        MEM_SIZE_WORD = 2'd2
    } mem_size_e;

    // same encoding as the bus opcode
    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_opcode_e;

    //################################################
    // payloads
    //################################################
    typedef struct packed {
        logic      is_store;
        mem_size_e size;
        logic      is_signed;
        inst_idx_t inst_id;
        phy_reg_t  rd;
        addr_t     base;
        offset_t   offset;
        reg_data_t st_data;
    } lsu_op_t;

    typedef struct packed {
        logic      is_store;
        mem_size_e size;
        logic      is_signed;
        inst_idx_t inst_id;
        phy_reg_t  rd;
        addr_t     addr;
        reg_data_t st_data;
    } agu_op_t;

    // travels through memory and comes back with the read data
    typedef struct packed {
        inst_idx_t inst_id;
        phy_reg_t  rd;
        mem_size_e size;
        logic      is_signed;
        lane_t     lane;
    } load_tag_t;

    typedef struct packed {
        addr_t       addr;
        mem_opcode_e opcode;
        line_data_t  data;
        line_strb_t  strb;
        load_tag_t   sideband;
    } mem_req_t;

endpackage
